//--- Makefile
# Verilator flow for the VGA colour bar demo

TOP := tb_vga_demo

.PHONY: lint sim clean

# lint the RTL on its own
lint:
	verilator --lint-only -Wall --top-module vga_demo_top \
		design/vga_pkg.sv design/raster_timing.sv \
		design/strip_pattern.sv design/vga_demo_top.sv

# build and run the testbench, a failing run exits non-zero
sim:
	verilator --binary --timing --assert -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- design/raster_timing.sv
//##########################################################################
// raster timing: pixel and line counters, visible area and sync flags
//##########################################################################
module raster_timing (
	input  logic                 clk,
	input  logic                 rst_n,
	output vga_pkg::raster_pos_t pos,
	output logic                 frame_end
);
	import vga_pkg::*;

	coord_t x_q;
	coord_t y_q;
	logic   x_last;
	logic   y_last;
	logic   visible;
	logic   hs_window;
	logic   vs_window;

	// last pixel of a line, last line of a frame
	assign x_last = (x_q == coord_t'(h_total - 1));
	assign y_last = (y_q == coord_t'(v_total - 1));

	// pixel counter, 0 to 799
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_q <= '0;
		end else if (x_last) begin
			x_q <= '0;
		end else begin
			x_q <= x_q + coord_t'(1);
		end
	end

	// line counter, only moves when the pixel counter wraps
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y_q <= '0;
		end else if (x_last) begin
			if (y_last) begin
				y_q <= '0;
			end else begin
				y_q <= y_q + coord_t'(1);
			end
		end
	end

	assign visible = (x_q < coord_t'(h_visible)) && (y_q < coord_t'(v_visible));

	// hsync pulse starts right after the front porch, pixels 656 to 751
	assign hs_window = (x_q >= coord_t'(h_visible + h_front))
		&& (x_q < coord_t'(h_visible + h_front + h_sync));

	// vsync pulse on lines 490 and 491
	assign vs_window = (y_q >= coord_t'(v_visible + v_front))
		&& (y_q < coord_t'(v_visible + v_front + v_sync));

	// describes the current pixel, no extra register stage
	always_comb begin
		pos.x         = x_q;
		pos.y         = y_q;
		pos.active    = visible;
		pos.hs_active = hs_window;
		pos.vs_active = vs_window;
	end

	// one cycle wide, on pixel (799, 524)
	assign frame_end = x_last && y_last;

	counters_in_frame: assert property (
		@(posedge clk) disable iff (!rst_n)
		(x_q < coord_t'(h_total)) && (y_q < coord_t'(v_total))
	);

	// the frame strobe is always followed by the origin
	frame_wraps_to_origin: assert property (
		@(posedge clk) disable iff (!rst_n)
		frame_end |=> (x_q == '0) && (y_q == '0)
	);

endmodule

//--- design/strip_pattern.sv
//##########################################################################
// colour bar pattern: frame counter, gradient and strip colour,
// registered colour and active-low sync outputs
//##########################################################################
module strip_pattern (
	input  logic                 clk,
	input  logic                 rst_n,
	input  vga_pkg::raster_pos_t pos,
	input  logic                 frame_end,
	output vga_pkg::rgb_t        rgb,
	output logic                 hsync,
	output logic                 vsync
);
	import vga_pkg::*;

	frame_count_t frame_q;
	strip_t       strip;
	logic         in_gradient;
	rgb_t         bar_colour;
	rgb_t         colour_next;

	// frame number, steps on the last pixel of each frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_q <= '0;
		end else if (frame_end) begin
			frame_q <= frame_q + frame_count_t'(1);
		end
	end

	// 64 pixels per strip
	assign strip = strip_t'(pos.x >> strip_shift);

	assign in_gradient = (pos.x < coord_t'(gradient_width));

	// one lit bit per strip, r2 first and b0 last
	always_comb begin
		bar_colour = '0;
		case (strip)
			strip_t'(0): begin
				bar_colour.r[2] = 1'b1;
			end
			strip_t'(1): begin
				bar_colour.r[1] = 1'b1;
			end
			strip_t'(2): begin
				bar_colour.r[0] = 1'b1;
			end
			strip_t'(3): begin
				bar_colour.g[2] = 1'b1;
			end
			strip_t'(4): begin
				bar_colour.g[1] = 1'b1;
			end
			strip_t'(5): begin
				bar_colour.g[0] = 1'b1;
			end
			strip_t'(6): begin
				bar_colour.b[2] = 1'b1;
			end
			strip_t'(7): begin
				bar_colour.b[1] = 1'b1;
			end
			strip_t'(8): begin
				bar_colour.b[0] = 1'b1;
			end
			// strips 9 and up stay dark
			default: begin
				bar_colour = '0;
			end
		endcase
	end

	// blanking first, then gradient columns, then bars
	always_comb begin
		if (!pos.active) begin
			colour_next = '0;
		end else if (in_gradient) begin
			// frame bits 8:6 to r, 5:3 to g, 2:0 to b
			colour_next = rgb_t'(frame_q);
		end else begin
			colour_next = bar_colour;
		end
	end

	// colour and sync taken from the same pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			rgb   <= colour_next;
			hsync <= !pos.hs_active;
			vsync <= !pos.vs_active;
		end
	end

	// nothing is lit outside the visible area
	blank_outside_visible: assert property (
		@(posedge clk) disable iff (!rst_n)
		!pos.active |=> (rgb == '0)
	);

endmodule

//--- design/vga_demo_top.sv
//##########################################################################
// VGA colour bar demo top: raster timing feeding the bar pattern
//##########################################################################
module vga_demo_top (
	input  logic          clk,
	input  logic          rst_n,
	output vga_pkg::rgb_t rgb,
	output logic          hsync,
	output logic          vsync
);
	import vga_pkg::*;

	// pixel currently being scanned
	raster_pos_t pos;

	// last pixel of the frame
	logic frame_end;

	// counters and flags for the current pixel
	raster_timing u_timing (
		.clk       (clk),
		.rst_n     (rst_n),
		.pos       (pos),
		.frame_end (frame_end)
	);

	// colour and sync, one pixel behind the counters
	strip_pattern u_pattern (
		.clk       (clk),
		.rst_n     (rst_n),
		.pos       (pos),
		.frame_end (frame_end),
		.rgb       (rgb),
		.hsync     (hsync),
		.vsync     (vsync)
	);

endmodule

//--- design/vga_pkg.sv
//##########################################################################
// 640x480 frame geometry, coordinate and colour types,
// raster position and pixel colour structs
//##########################################################################
package vga_pkg;

	// horizontal geometry in pixel clocks
	localparam int h_visible = 640;
	localparam int h_front   = 16;
	localparam int h_sync    = 96;
	localparam int h_total   = 800;

	// vertical geometry in lines
	localparam int v_visible = 480;
	localparam int v_front   = 10;
	localparam int v_sync    = 2;
	localparam int v_total   = 525;

	// leftmost columns show the frame number
	localparam int gradient_width = 32;

	// x bits dropped to pick a 64-pixel strip
	localparam int strip_shift = 6;

	// pixel column or line number
	typedef logic [9:0] coord_t;

	// intensity of one channel
	typedef logic [2:0] colour_t;

	// wraps after 512 frames
	typedef logic [8:0] frame_count_t;

	// colour bar index, x / 64
	typedef logic [3:0] strip_t;

	// everything known about the pixel being scanned
	typedef struct packed {
		coord_t x;
		coord_t y;
		// inside the 640x480 area
		logic   active;
		// inside the sync pulses, active high here
		logic   hs_active;
		logic   vs_active;
	} raster_pos_t;

	// r in the top bits, b in the bottom bits
	typedef struct packed {
		colour_t r;
		colour_t g;
		colour_t b;
	} rgb_t;

endpackage

//--- sim/tb_vga_checks.svh
//##########################################################################
// compare tasks for colour and sync, expected colour and sync levels
//##########################################################################

// one colour sample against its expected value
task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
	if (actual !== expected) begin
		stop_on_error($sformatf("ERROR at %0d ns: %s is %03o, expected %03o",
			$time, name, actual, expected));
	end
endtask

// one sync level against its expected value
task automatic check_sync(input string name, input logic actual, input logic expected);
	if (actual !== expected) begin
		stop_on_error($sformatf("ERROR at %0d ns: %s is %b, expected %b",
			$time, name, actual, expected));
	end
endtask

// colour of a pixel, from the screen layout of the demo
function automatic rgb_t expected_colour(input int x, input int y, input frame_count_t frame);
	rgb_t       colour;
	logic [8:0] lit;
	int         strip;
	colour = '0;
	lit = '0;
	strip = x / 64;
	if ((x < 640) && (y < 480)) begin
		if (x < 32) begin
			colour.r = frame[8:6];
			colour.g = frame[5:3];
			colour.b = frame[2:0];
		end else if (strip <= 8) begin
			// strip 0 lights the top red bit, strip 8 the low blue bit
			lit = 9'b1_0000_0000 >> strip;
			colour.r = lit[8:6];
			colour.g = lit[5:3];
			colour.b = lit[2:0];
		end
	end
	return colour;
endfunction

// hsync is low on pixels 656 to 751
function automatic logic expected_hsync(input int x);
	return ((x >= 656) && (x <= 751)) ? 1'b0 : 1'b1;
endfunction

// vsync is low on lines 490 and 491
function automatic logic expected_vsync(input int y);
	return ((y == 490) || (y == 491)) ? 1'b0 : 1'b1;
endfunction

//--- sim/tb_vga_demo.sv
//##########################################################################
// testbench for the VGA colour bar demo: clock, reset, checkpoint table,
// raster model, cycle limit and the pass or fail ending
//##########################################################################
module tb_vga_demo;
	timeunit 1ns;
	timeprecision 1ps;

	import vga_pkg::*;

	// pixel clocks in one frame
	localparam int frame_cycles = h_total * v_total;
	// checkpoints span less than three frames
	localparam int timeout_cycles = 3 * frame_cycles + 10000;
	localparam int reset_cycles = 4;

	typedef struct packed {
		frame_count_t frame;
		coord_t       x;
		coord_t       y;
		rgb_t         colour;
		logic         hsync;
		logic         vsync;
		// pulse reset before this row is reached
		logic         reset_before;
	} checkpoint_t;

	logic clk;
	logic rst_n;
	rgb_t rgb;
	logic hsync;
	logic vsync;

	// pixel that the outputs show at the current falling edge
	int model_x;
	int model_y;
	int model_frame;

	int          cycle_count = 0;
	checkpoint_t rows[$];

	vga_demo_top u_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.rgb   (rgb),
		.hsync (hsync),
		.vsync (vsync)
	);

	initial clk = 1'b0;

	// 20 ns pixel clock
	always #10 clk = !clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			stop_on_error($sformatf("timeout: the run did not finish within %0d cycles",
				timeout_cycles));
		end
	end

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at the first failure");
	endtask

	`include "tb_vga_checks.svh"

	function automatic checkpoint_t make_checkpoint(input int frame, input int x, input int y,
		input logic [8:0] colour, input logic hs, input logic vs, input logic reset_before);
		checkpoint_t row;
		row.frame = frame_count_t'(frame);
		row.x = coord_t'(x);
		row.y = coord_t'(y);
		row.colour = rgb_t'(colour);
		row.hsync = hs;
		row.vsync = vs;
		row.reset_before = reset_before;
		return row;
	endfunction

	// rows in raster order, colour as octal r g b digits
	function automatic void load_table();
		// frame 0, gradient and the nine strips on line 100
		rows.push_back(make_checkpoint(0, 0, 0, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 31, 0, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 32, 100, 9'o400, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 64, 100, 9'o200, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 128, 100, 9'o100, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 192, 100, 9'o040, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 256, 100, 9'o020, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 320, 100, 9'o010, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 384, 100, 9'o004, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 448, 100, 9'o002, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 512, 100, 9'o001, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 576, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 600, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 639, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		// horizontal blanking and the edges of the hsync pulse
		rows.push_back(make_checkpoint(0, 640, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 655, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 656, 100, 9'o000, 1'b0, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 751, 100, 9'o000, 1'b0, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 752, 100, 9'o000, 1'b1, 1'b1, 1'b0));
		// last visible line, then vertical blanking
		rows.push_back(make_checkpoint(0, 100, 479, 9'o200, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 100, 480, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 100, 490, 9'o000, 1'b1, 1'b0, 1'b0));
		rows.push_back(make_checkpoint(0, 700, 491, 9'o000, 1'b0, 1'b0, 1'b0));
		rows.push_back(make_checkpoint(0, 100, 492, 9'o000, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 799, 524, 9'o000, 1'b1, 1'b1, 1'b0));
		// gradient follows the frame number
		rows.push_back(make_checkpoint(1, 0, 0, 9'o001, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(1, 64, 200, 9'o200, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(1, 31, 479, 9'o001, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(2, 0, 10, 9'o002, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(2, 31, 300, 9'o002, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(2, 576, 479, 9'o000, 1'b1, 1'b1, 1'b0));
		// mid-frame reset, raster and frame count start over
		rows.push_back(make_checkpoint(0, 0, 0, 9'o000, 1'b1, 1'b1, 1'b1));
		rows.push_back(make_checkpoint(0, 32, 0, 9'o400, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 100, 1, 9'o200, 1'b1, 1'b1, 1'b0));
		rows.push_back(make_checkpoint(0, 656, 1, 9'o000, 1'b0, 1'b1, 1'b0));
	endfunction

	// holds reset for four edges, outputs must stay dark and idle
	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (reset_cycles) begin
			@(negedge clk);
			check_rgb("rgb", rgb, '0);
			check_sync("hsync", hsync, 1'b1);
			check_sync("vsync", vsync, 1'b1);
		end
		rst_n = 1'b1;
		// first edge after release registers pixel (0,0) of frame 0
		model_x = 0;
		model_y = 0;
		model_frame = 0;
	endtask

	// raster order, one pixel per clock
	function automatic void advance_model();
		if (model_x == h_total - 1) begin
			model_x = 0;
			if (model_y == v_total - 1) begin
				model_y = 0;
				model_frame = model_frame + 1;
			end else begin
				model_y = model_y + 1;
			end
		end else begin
			model_x = model_x + 1;
		end
	endfunction

	// checked on every pixel
	task automatic check_pixel_rules();
		rgb_t colour;
		colour = expected_colour(model_x, model_y, frame_count_t'(model_frame));
		check_rgb("rgb", rgb, colour);
		check_sync("hsync", hsync, expected_hsync(model_x));
		check_sync("vsync", vsync, expected_vsync(model_y));
	endtask

	function automatic logic at_checkpoint(input checkpoint_t row);
		return (model_frame == int'(row.frame)) && (model_x == int'(row.x))
			&& (model_y == int'(row.y));
	endfunction

	task automatic check_checkpoint(input checkpoint_t row);
		check_rgb("rgb at checkpoint", rgb, row.colour);
		check_sync("hsync at checkpoint", hsync, row.hsync);
		check_sync("vsync at checkpoint", vsync, row.vsync);
	endtask

	initial begin : main
		checkpoint_t row;
		logic        reached;
		rst_n = 1'b0;
		model_x = 0;
		model_y = 0;
		model_frame = 0;
		load_table();
		apply_reset();
		foreach (rows[i]) begin
			row = rows[i];
			if (row.reset_before) begin
				apply_reset();
			end
			reached = 1'b0;
			// step pixel by pixel until the model reaches the row
			while (!reached) begin
				@(negedge clk);
				check_pixel_rules();
				reached = at_checkpoint(row);
				if (reached) begin
					check_checkpoint(row);
				end
				advance_model();
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- sources.f
+incdir+sim
design/vga_pkg.sv
design/raster_timing.sv
design/strip_pattern.sv
design/vga_demo_top.sv
sim/tb_vga_demo.sv
